// ==== hw/mem_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared types of the memory subsystem
////////////////////////////////////////////////////////////////////////////

package mem_pkg;

    // Size of one access
    // A byte takes one 8-bit lane, a word takes both
    typedef enum logic {
        size_byte = 1'b0,
        size_word = 1'b1
    } access_size_e;

    // Cause of the first recorded fault
    typedef enum logic [1:0] {
        fault_none  = 2'd0,
        fault_write = 2'd1,
        fault_read  = 2'd2
    } fault_kind_e;

endpackage

`default_nettype wire

// ==== hw/banked_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_ram #(
    parameter int MEM_DEPTH   = 1024,
    parameter int WORD_SIZE   = 16,
    parameter int RD_CHANNELS = 2
) (
    input  logic                            clk,
    input  logic                            reset,

    // Write side
    input  logic [1:0]                      mem_wr_en,
    input  logic [$clog2(MEM_DEPTH)-1:0]    mem_wr_addr,
    input  logic [WORD_SIZE-1:0]            mem_wr_data,

    // Read side
    input  logic                            mem_rd_en   [RD_CHANNELS],
    input  logic [$clog2(MEM_DEPTH)-1:0]    mem_rd_addr [RD_CHANNELS],

    output logic                            mem_rd_done [RD_CHANNELS],
    output logic [WORD_SIZE-1:0]            mem_rd_data [RD_CHANNELS]
);

    localparam int H_WORD = WORD_SIZE / 2;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Lane 0 holds even bytes, lane 1 odd bytes
    logic [H_WORD-1:0] lane_mem [2][MEM_DEPTH];

    // Each lane written under its own enable
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 2; lane++) begin
            if (mem_wr_en[lane]) begin
                lane_mem[lane][mem_wr_addr] <= mem_wr_data[lane*H_WORD +: H_WORD];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < RD_CHANNELS; ch++) begin : g_rd_port
        // Done pulse one cycle after the enable
        always_ff @(posedge clk) begin
            if (reset) begin
                mem_rd_done[ch] <= 1'b0;
            end else begin
                mem_rd_done[ch] <= mem_rd_en[ch];
            end
        end

        // Old contents on a same-cycle write
        always_ff @(posedge clk) begin
            if (mem_rd_en[ch]) begin
                mem_rd_data[ch] <= {lane_mem[1][mem_rd_addr[ch]],
                                    lane_mem[0][mem_rd_addr[ch]]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/fault_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module fault_status #(
    parameter int RD_CHANNELS = 2,
    parameter int MEM_DEPTH   = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            fault_clear,

    // Pulses from the controller with their word addresses
    input  logic                            invalid_wr_addr,
    input  logic [$clog2(MEM_DEPTH)-1:0]    mem_wr_addr,
    input  logic                            invalid_rd_addr [RD_CHANNELS],
    input  logic [$clog2(MEM_DEPTH)-1:0]    mem_rd_addr     [RD_CHANNELS],

    // Sticky status
    output logic                            wr_fault,
    output logic                            rd_fault        [RD_CHANNELS],
    output mem_pkg::fault_kind_e            fault_kind,
    output logic [$clog2(MEM_DEPTH):0]      fault_addr
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    mem_pkg::fault_kind_e new_kind;
    logic [ADDR_W:0]      new_addr;

    // Fault of this cycle, write first, then lowest channel
    // Only odd word accesses fault, so bit 0 of the byte address is set
    always_comb begin
        new_kind = mem_pkg::fault_none;
        new_addr = '0;
        if (invalid_wr_addr) begin
            new_kind = mem_pkg::fault_write;
            new_addr = {mem_wr_addr, 1'b1};
        end else begin
            for (int ch = RD_CHANNELS - 1; ch >= 0; ch--) begin
                if (invalid_rd_addr[ch]) begin
                    new_kind = mem_pkg::fault_read;
                    new_addr = {mem_rd_addr[ch], 1'b1};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_fault   <= 1'b0;
            fault_kind <= mem_pkg::fault_none;
            fault_addr <= '0;
            for (int ch = 0; ch < RD_CHANNELS; ch++) begin
                rd_fault[ch] <= 1'b0;
            end
        end else if (fault_clear) begin
            // A fault in the clear cycle survives as the new first fault
            wr_fault   <= invalid_wr_addr;
            fault_kind <= new_kind;
            fault_addr <= new_addr;
            for (int ch = 0; ch < RD_CHANNELS; ch++) begin
                rd_fault[ch] <= invalid_rd_addr[ch];
            end
        end else begin
            wr_fault <= wr_fault | invalid_wr_addr;
            for (int ch = 0; ch < RD_CHANNELS; ch++) begin
                rd_fault[ch] <= rd_fault[ch] | invalid_rd_addr[ch];
            end
            if (fault_kind == mem_pkg::fault_none && new_kind != mem_pkg::fault_none) begin
                fault_kind <= new_kind;
                fault_addr <= new_addr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_memory_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_memory_controller #(
    parameter int MEM_DEPTH   = 1024,
    parameter int WORD_SIZE   = 16,
    parameter int RD_CHANNELS = 2
) (
    input  logic                            clk,
    input  logic                            reset,

    // Write request
    input  logic                            wr_en,
    input  mem_pkg::access_size_e           wr_size,
    input  logic [WORD_SIZE-1:0]            wr_addr,
    input  logic [WORD_SIZE-1:0]            wr_data,

    // Read requests
    input  logic                            rd_en       [RD_CHANNELS],
    input  mem_pkg::access_size_e           rd_size     [RD_CHANNELS],
    input  logic [WORD_SIZE-1:0]            rd_addr     [RD_CHANNELS],

    // Returned RAM data
    input  logic                            mem_rd_done [RD_CHANNELS],
    input  logic [WORD_SIZE-1:0]            mem_rd_data [RD_CHANNELS],

    // RAM access
    output logic [1:0]                      mem_wr_en,
    output logic [$clog2(MEM_DEPTH)-1:0]    mem_wr_addr,
    output logic [WORD_SIZE-1:0]            mem_wr_data,
    output logic                            mem_rd_en   [RD_CHANNELS],
    output logic [$clog2(MEM_DEPTH)-1:0]    mem_rd_addr [RD_CHANNELS],

    // Completions
    output logic                            rd_done     [RD_CHANNELS],
    output logic [WORD_SIZE-1:0]            rd_data     [RD_CHANNELS],

    // Fault pulses
    output logic                            invalid_wr_addr,
    output logic                            invalid_rd_addr [RD_CHANNELS]
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);
    localparam int H_WORD = WORD_SIZE / 2;

    logic wr_misaligned;

    // Word access to an odd byte address
    assign wr_misaligned = (wr_size == mem_pkg::size_word) && wr_addr[0];

    ////////////////////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////////////////////

    // Lane enables and fault pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wr_en       <= 2'b00;
            invalid_wr_addr <= 1'b0;
        end else begin
            invalid_wr_addr <= wr_en && wr_misaligned;
            if (!wr_en || wr_misaligned) begin
                mem_wr_en <= 2'b00;
            end else if (wr_size == mem_pkg::size_word) begin
                mem_wr_en <= 2'b11;
            end else begin
                // Bit 0 is the even byte, bit 1 the odd byte
                mem_wr_en <= {wr_addr[0], ~wr_addr[0]};
            end
        end
    end

    // Word address and steered data
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_wr_addr <= wr_addr[ADDR_W:1];
            if (wr_size == mem_pkg::size_word) begin
                mem_wr_data <= wr_data;
            end else begin
                // Same byte on both lanes, the enable picks one
                mem_wr_data <= {wr_data[H_WORD-1:0], wr_data[H_WORD-1:0]};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read channels
    ////////////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < RD_CHANNELS; ch++) begin : g_rd_chan
        // Request attributes travelling with the access
        mem_pkg::access_size_e size_s1;
        mem_pkg::access_size_e size_s2;
        logic                  lsb_s1;
        logic                  lsb_s2;
        logic [H_WORD-1:0]     sel_byte;

        // Byte picked from the returned word
        assign sel_byte = lsb_s2 ? mem_rd_data[ch][WORD_SIZE-1:H_WORD]
                                 : mem_rd_data[ch][H_WORD-1:0];

        // Strobes of the pipeline
        always_ff @(posedge clk) begin
            if (reset) begin
                mem_rd_en[ch]       <= 1'b0;
                invalid_rd_addr[ch] <= 1'b0;
                rd_done[ch]         <= 1'b0;
            end else begin
                mem_rd_en[ch]       <= rd_en[ch];
                invalid_rd_addr[ch] <= rd_en[ch] && (rd_size[ch] == mem_pkg::size_word)
                                       && rd_addr[ch][0];
                rd_done[ch]         <= mem_rd_done[ch];
            end
        end

        // Stage 1 captures the request
        always_ff @(posedge clk) begin
            if (rd_en[ch]) begin
                mem_rd_addr[ch] <= rd_addr[ch][ADDR_W:1];
                size_s1         <= rd_size[ch];
                lsb_s1          <= rd_addr[ch][0];
            end
        end

        // Stage 2 runs beside the RAM access
        always_ff @(posedge clk) begin
            size_s2 <= size_s1;
            lsb_s2  <= lsb_s1;
        end

        // Stage 3 shapes the returned word
        always_ff @(posedge clk) begin
            if (mem_rd_done[ch]) begin
                if (size_s2 == mem_pkg::size_word) begin
                    rd_data[ch] <= mem_rd_data[ch];
                end else begin
                    rd_data[ch] <= {sel_byte, sel_byte};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
    parameter int MEM_DEPTH   = 1024,
    parameter int WORD_SIZE   = 16,
    parameter int RD_CHANNELS = 2
) (
    input  logic                            clk,
    input  logic                            reset,

    // Write request
    input  logic                            wr_en,
    input  mem_pkg::access_size_e           wr_size,
    input  logic [WORD_SIZE-1:0]            wr_addr,
    input  logic [WORD_SIZE-1:0]            wr_data,

    // Read requests and completions
    input  logic                            rd_en    [RD_CHANNELS],
    input  mem_pkg::access_size_e           rd_size  [RD_CHANNELS],
    input  logic [WORD_SIZE-1:0]            rd_addr  [RD_CHANNELS],
    output logic                            rd_done  [RD_CHANNELS],
    output logic [WORD_SIZE-1:0]            rd_data  [RD_CHANNELS],

    // Fault status
    input  logic                            fault_clear,
    output logic                            wr_fault,
    output logic                            rd_fault [RD_CHANNELS],
    output mem_pkg::fault_kind_e            fault_kind,
    output logic [$clog2(MEM_DEPTH):0]      fault_addr
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    // Controller to RAM
    logic [1:0]           mem_wr_en;
    logic [ADDR_W-1:0]    mem_wr_addr;
    logic [WORD_SIZE-1:0] mem_wr_data;
    logic                 mem_rd_en       [RD_CHANNELS];
    logic [ADDR_W-1:0]    mem_rd_addr     [RD_CHANNELS];

    // RAM to controller
    logic                 mem_rd_done     [RD_CHANNELS];
    logic [WORD_SIZE-1:0] mem_rd_data     [RD_CHANNELS];

    // Controller to fault status
    logic                 invalid_wr_addr;
    logic                 invalid_rd_addr [RD_CHANNELS];

    cpu_memory_controller #(
        .MEM_DEPTH   (MEM_DEPTH),
        .WORD_SIZE   (WORD_SIZE),
        .RD_CHANNELS (RD_CHANNELS)
    ) u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .wr_en           (wr_en),
        .wr_size         (wr_size),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .rd_en           (rd_en),
        .rd_size         (rd_size),
        .rd_addr         (rd_addr),
        .mem_rd_done     (mem_rd_done),
        .mem_rd_data     (mem_rd_data),
        .mem_wr_en       (mem_wr_en),
        .mem_wr_addr     (mem_wr_addr),
        .mem_wr_data     (mem_wr_data),
        .mem_rd_en       (mem_rd_en),
        .mem_rd_addr     (mem_rd_addr),
        .rd_done         (rd_done),
        .rd_data         (rd_data),
        .invalid_wr_addr (invalid_wr_addr),
        .invalid_rd_addr (invalid_rd_addr)
    );

    banked_ram #(
        .MEM_DEPTH   (MEM_DEPTH),
        .WORD_SIZE   (WORD_SIZE),
        .RD_CHANNELS (RD_CHANNELS)
    ) u_ram (
        .clk         (clk),
        .reset       (reset),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_done (mem_rd_done),
        .mem_rd_data (mem_rd_data)
    );

    fault_status #(
        .RD_CHANNELS (RD_CHANNELS),
        .MEM_DEPTH   (MEM_DEPTH)
    ) u_fault (
        .clk             (clk),
        .reset           (reset),
        .fault_clear     (fault_clear),
        .invalid_wr_addr (invalid_wr_addr),
        .mem_wr_addr     (mem_wr_addr),
        .invalid_rd_addr (invalid_rd_addr),
        .mem_rd_addr     (mem_rd_addr),
        .wr_fault        (wr_fault),
        .rd_fault        (rd_fault),
        .fault_kind      (fault_kind),
        .fault_addr      (fault_addr)
    );

endmodule

`default_nettype wire

// ==== tests/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int MEM_DEPTH       = 1024;
    localparam int WORD_SIZE       = 16;
    localparam int RD_CHANNELS     = 2;
    localparam int ADDR_W          = $clog2(MEM_DEPTH);
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_CYCLES   = 400;
    localparam int MARGIN_CYCLES   = 200;

    logic                  clk;
    logic                  reset;
    logic                  wr_en;
    mem_pkg::access_size_e wr_size;
    logic [WORD_SIZE-1:0]  wr_addr;
    logic [WORD_SIZE-1:0]  wr_data;
    logic                  rd_en      [RD_CHANNELS];
    mem_pkg::access_size_e rd_size    [RD_CHANNELS];
    logic [WORD_SIZE-1:0]  rd_addr    [RD_CHANNELS];
    logic                  rd_done    [RD_CHANNELS];
    logic [WORD_SIZE-1:0]  rd_data    [RD_CHANNELS];
    logic                  fault_clear;
    logic                  wr_fault;
    logic                  rd_fault   [RD_CHANNELS];
    mem_pkg::fault_kind_e  fault_kind;
    logic [ADDR_W:0]       fault_addr;

    // Requests for the next cycle
    logic                  hold_reset;
    logic                  nx_wr_en;
    mem_pkg::access_size_e nx_wr_size;
    logic [WORD_SIZE-1:0]  nx_wr_addr;
    logic [WORD_SIZE-1:0]  nx_wr_data;
    logic                  nx_rd_en   [RD_CHANNELS];
    mem_pkg::access_size_e nx_rd_size [RD_CHANNELS];
    logic [WORD_SIZE-1:0]  nx_rd_addr [RD_CHANNELS];
    logic                  nx_clear;

    // Reference memory with one array per byte lane
    logic [7:0]            ref_lo     [MEM_DEPTH];
    logic [7:0]            ref_hi     [MEM_DEPTH];
    logic [WORD_SIZE-1:0]  exp_q      [RD_CHANNELS][$];
    logic [WORD_SIZE-1:0]  exp_data   [RD_CHANNELS];
    logic [2:0]            en_hist    [RD_CHANNELS];

    // Fault model with pending pulses and the state due at the next edge
    logic                  m_wr;
    logic                  m_rd       [RD_CHANNELS];
    mem_pkg::fault_kind_e  m_kind;
    logic [ADDR_W:0]       m_addr;
    logic                  p_wr;
    logic                  p_rd       [RD_CHANNELS];
    mem_pkg::fault_kind_e  p_kind;
    logic [ADDR_W:0]       p_addr;
    logic                  chk_wr;
    logic                  chk_rd     [RD_CHANNELS];
    mem_pkg::fault_kind_e  chk_kind;
    logic [ADDR_W:0]       chk_addr;

    logic                  checking;
    int                    assert_errors;
    int                    model_errors;
    logic [31:0]           lcg_state;

    mem_subsystem_top #(
        .MEM_DEPTH   (MEM_DEPTH),
        .WORD_SIZE   (WORD_SIZE),
        .RD_CHANNELS (RD_CHANNELS)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_size     (wr_size),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_size     (rd_size),
        .rd_addr     (rd_addr),
        .rd_done     (rd_done),
        .rd_data     (rd_data),
        .fault_clear (fault_clear),
        .wr_fault    (wr_fault),
        .rd_fault    (rd_fault),
        .fault_kind  (fault_kind),
        .fault_addr  (fault_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Request history for the latency check
    always @(posedge clk) begin
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            if (reset) begin
                en_hist[ch] <= 3'b000;
            end else begin
                en_hist[ch] <= {en_hist[ch][1:0], rd_en[ch]};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < RD_CHANNELS; ch++) begin : g_chk
        // Completion exactly three cycles after the request
        a_latency: assert property (@(posedge clk) disable iff (!checking)
            rd_done[ch] == en_hist[ch][2])
        else begin
            assert_errors++;
            $display("Mismatch rd_done[%0d]: got %h expected %h", ch,
                     $sampled(rd_done[ch]), $sampled(en_hist[ch][2]));
        end

        a_data: assert property (@(posedge clk) disable iff (!checking)
            rd_done[ch] |-> rd_data[ch] == exp_data[ch])
        else begin
            assert_errors++;
            $display("Mismatch rd_data[%0d]: got %h expected %h", ch,
                     $sampled(rd_data[ch]), $sampled(exp_data[ch]));
        end

        a_rd_fault: assert property (@(posedge clk) disable iff (!checking)
            rd_fault[ch] == chk_rd[ch])
        else begin
            assert_errors++;
            $display("Mismatch rd_fault[%0d]: got %h expected %h", ch,
                     $sampled(rd_fault[ch]), $sampled(chk_rd[ch]));
        end
    end

    a_wr_fault: assert property (@(posedge clk) disable iff (!checking)
        wr_fault == chk_wr)
    else begin
        assert_errors++;
        $display("Mismatch wr_fault: got %h expected %h", $sampled(wr_fault), $sampled(chk_wr));
    end

    a_fault_kind: assert property (@(posedge clk) disable iff (!checking)
        fault_kind == chk_kind)
    else begin
        assert_errors++;
        $display("Mismatch fault_kind: got %h expected %h",
                 $sampled(fault_kind), $sampled(chk_kind));
    end

    a_fault_addr: assert property (@(posedge clk) disable iff (!checking)
        fault_addr == chk_addr)
    else begin
        assert_errors++;
        $display("Mismatch fault_addr: got %h expected %h",
                 $sampled(fault_addr), $sampled(chk_addr));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Distinct value for every word address
    function automatic logic [15:0] fill_word(input int w);
        return 16'(w * 40503) ^ 16'h5ac3;
    endfunction

    task automatic queue_write(input mem_pkg::access_size_e size, input logic [15:0] addr,
                               input logic [15:0] data);
        nx_wr_en   = 1'b1;
        nx_wr_size = size;
        nx_wr_addr = addr;
        nx_wr_data = data;
    endtask

    task automatic queue_read(input int ch, input mem_pkg::access_size_e size,
                              input logic [15:0] addr);
        nx_rd_en[ch]   = 1'b1;
        nx_rd_size[ch] = size;
        nx_rd_addr[ch] = addr;
    endtask

    task automatic clear_requests();
        nx_wr_en   = 1'b0;
        nx_wr_size = mem_pkg::size_byte;
        nx_wr_addr = '0;
        nx_wr_data = '0;
        nx_clear   = 1'b0;
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            nx_rd_en[ch]   = 1'b0;
            nx_rd_size[ch] = mem_pkg::size_byte;
            nx_rd_addr[ch] = '0;
        end
    endtask

    // Pulses of last cycle land together with this cycle's clear
    task automatic update_faults();
        if (nx_clear) begin
            m_wr   = p_wr;
            m_kind = p_kind;
            m_addr = p_addr;
        end else begin
            m_wr = m_wr | p_wr;
            if (m_kind == mem_pkg::fault_none && p_kind != mem_pkg::fault_none) begin
                m_kind = p_kind;
                m_addr = p_addr;
            end
        end
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            m_rd[ch] = nx_clear ? p_rd[ch] : (m_rd[ch] | p_rd[ch]);
        end
    endtask

    // Only odd word accesses fault
    // The write beats any read and a lower channel beats a higher one
    task automatic latch_pulses();
        p_wr   = nx_wr_en && nx_wr_size == mem_pkg::size_word && nx_wr_addr[0];
        p_kind = mem_pkg::fault_none;
        p_addr = '0;
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            p_rd[ch] = nx_rd_en[ch] && nx_rd_size[ch] == mem_pkg::size_word
                       && nx_rd_addr[ch][0];
            if (p_rd[ch] && p_kind == mem_pkg::fault_none) begin
                p_kind = mem_pkg::fault_read;
                p_addr = nx_rd_addr[ch][ADDR_W:0];
            end
        end
        if (p_wr) begin
            p_kind = mem_pkg::fault_write;
            p_addr = nx_wr_addr[ADDR_W:0];
        end
    endtask

    // Reads see memory before this cycle's write
    task automatic predict_reads();
        logic [ADDR_W-1:0] w;
        logic [7:0]        b;
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            if (nx_rd_en[ch]) begin
                w = nx_rd_addr[ch][ADDR_W:1];
                b = nx_rd_addr[ch][0] ? ref_hi[w] : ref_lo[w];
                if (nx_rd_size[ch] == mem_pkg::size_word) begin
                    exp_q[ch].push_back({ref_hi[w], ref_lo[w]});
                end else begin
                    exp_q[ch].push_back({b, b});
                end
            end
        end
    endtask

    task automatic apply_write();
        logic [ADDR_W-1:0] w;
        w = nx_wr_addr[ADDR_W:1];
        if (nx_wr_en && nx_wr_size == mem_pkg::size_word && !nx_wr_addr[0]) begin
            ref_lo[w] = nx_wr_data[7:0];
            ref_hi[w] = nx_wr_data[15:8];
        end else if (nx_wr_en && nx_wr_size == mem_pkg::size_byte) begin
            if (nx_wr_addr[0]) begin
                ref_hi[w] = nx_wr_data[7:0];
            end else begin
                ref_lo[w] = nx_wr_data[7:0];
            end
        end
    endtask

    // One clock cycle that retires completions, drives requests and advances the model
    task automatic step();
        @(negedge clk);
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            if (rd_done[ch] === 1'b1) begin
                if (exp_q[ch].size() == 0) begin
                    model_errors++;
                    $display("Channel %0d returned data with no read outstanding", ch);
                end else begin
                    exp_data[ch] = exp_q[ch].pop_front();
                end
            end
        end
        reset       = hold_reset;
        wr_en       = nx_wr_en;
        wr_size     = nx_wr_size;
        wr_addr     = nx_wr_addr;
        wr_data     = nx_wr_data;
        fault_clear = nx_clear;
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            rd_en[ch]   = nx_rd_en[ch];
            rd_size[ch] = nx_rd_size[ch];
            rd_addr[ch] = nx_rd_addr[ch];
            chk_rd[ch]  = m_rd[ch];
        end
        chk_wr   = m_wr;
        chk_kind = m_kind;
        chk_addr = m_addr;
        if (hold_reset) begin
            m_wr   = 1'b0;
            m_kind = mem_pkg::fault_none;
            m_addr = '0;
            p_wr   = 1'b0;
            p_kind = mem_pkg::fault_none;
            p_addr = '0;
            for (int ch = 0; ch < RD_CHANNELS; ch++) begin
                m_rd[ch] = 1'b0;
                p_rd[ch] = 1'b0;
            end
        end else begin
            update_faults();
            predict_reads();
            apply_write();
            latch_pulses();
        end
        clear_requests();
    endtask

    task automatic drain();
        repeat (6) step();
    endtask

    task automatic check_drained();
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            if (exp_q[ch].size() != 0) begin
                model_errors++;
                $display("Channel %0d still has %0d reads outstanding", ch, exp_q[ch].size());
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] r;
        logic [15:0] a;
        logic [15:0] ra;
        reset         = 1'b1;
        hold_reset    = 1'b1;
        checking      = 1'b0;
        assert_errors = 0;
        model_errors  = 0;
        lcg_state     = 32'd67;
        clear_requests();
        wr_en       = 1'b0;
        wr_size     = mem_pkg::size_byte;
        wr_addr     = '0;
        wr_data     = '0;
        fault_clear = 1'b0;
        m_wr        = 1'b0;
        m_kind      = mem_pkg::fault_none;
        m_addr      = '0;
        p_wr        = 1'b0;
        p_kind      = mem_pkg::fault_none;
        p_addr      = '0;
        chk_wr      = 1'b0;
        chk_kind    = mem_pkg::fault_none;
        chk_addr    = '0;
        for (int ch = 0; ch < RD_CHANNELS; ch++) begin
            rd_en[ch]    = 1'b0;
            rd_size[ch]  = mem_pkg::size_byte;
            rd_addr[ch]  = '0;
            exp_data[ch] = '0;
            m_rd[ch]     = 1'b0;
            p_rd[ch]     = 1'b0;
            chk_rd[ch]   = 1'b0;
        end

        // Reset with outputs checked from the second cycle on
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            step();
            if (i == 1) begin
                checking = 1'b1;
            end
        end
        hold_reset = 1'b0;

        // Known contents in every word
        for (int w = 0; w < MEM_DEPTH; w++) begin
            queue_write(mem_pkg::size_word, 16'(w * 2), fill_word(w));
            step();
        end

        // Aligned words and then reads on both channels every cycle
        queue_write(mem_pkg::size_word, 16'h0010, 16'h1357);
        step();
        queue_write(mem_pkg::size_word, 16'h0012, 16'h2468);
        step();
        queue_write(mem_pkg::size_word, 16'h07fe, 16'hbeef);
        step();
        for (int i = 0; i < 8; i++) begin
            queue_read(0, mem_pkg::size_word, 16'(16'h0010 + 2 * i));
            queue_read(1, mem_pkg::size_word, i[0] ? 16'h07fe : 16'h0012);
            step();
        end
        drain();
        check_drained();

        // Byte lanes
        queue_write(mem_pkg::size_byte, 16'h0020, 16'h5511);
        step();
        queue_write(mem_pkg::size_byte, 16'h0021, 16'h6622);
        queue_read(1, mem_pkg::size_word, 16'h0020);
        step();
        queue_write(mem_pkg::size_byte, 16'h0033, 16'h77ab);
        queue_read(0, mem_pkg::size_byte, 16'h0020);
        queue_read(1, mem_pkg::size_word, 16'h0020);
        step();
        queue_read(0, mem_pkg::size_byte, 16'h0021);
        queue_read(1, mem_pkg::size_word, 16'h0032);
        step();
        queue_read(0, mem_pkg::size_byte, 16'h0033);
        queue_read(1, mem_pkg::size_byte, 16'h0032);
        step();
        drain();

        // Misaligned word write above the memory depth
        queue_write(mem_pkg::size_word, 16'hf841, 16'hdead);
        step();
        queue_read(0, mem_pkg::size_word, 16'h0040);
        queue_read(1, mem_pkg::size_byte, 16'h0041);
        step();
        drain();
        nx_clear = 1'b1;
        step();
        drain();

        // Misaligned read on channel 1 and later faults that keep the first record
        queue_read(1, mem_pkg::size_word, 16'h0123);
        step();
        repeat (3) step();
        queue_write(mem_pkg::size_word, 16'h0201, 16'h1234);
        queue_read(0, mem_pkg::size_word, 16'h0305);
        step();
        drain();
        nx_clear = 1'b1;
        step();
        drain();

        // Fault pulses on both channels in the clear cycle
        queue_read(0, mem_pkg::size_word, 16'h0011);
        queue_read(1, mem_pkg::size_word, 16'h0015);
        step();
        nx_clear = 1'b1;
        step();
        drain();
        nx_clear = 1'b1;
        step();
        drain();
        check_drained();

        // Random traffic dense in the low words for collisions
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r = next_rand();
            a = next_rand();
            if (r[1:0] != 2'b00) begin
                a = a & 16'h003f;
            end
            if (r[2]) begin
                queue_write(mem_pkg::access_size_e'(r[3]), a, next_rand());
            end
            for (int ch = 0; ch < RD_CHANNELS; ch++) begin
                ra = next_rand();
                if (r[4 + ch]) begin
                    if (r[8 + ch]) begin
                        ra = {a[15:1], ra[0]};
                    end else if (r[1:0] != 2'b00) begin
                        ra = ra & 16'h003f;
                    end
                    queue_read(ch, mem_pkg::access_size_e'(r[10 + ch]), ra);
                end
            end
            nx_clear = (r[15:12] == 4'b0000);
            step();
        end
        drain();
        check_drained();

        $display("Assertion errors: %0d, model errors: %0d", assert_errors, model_errors);
        if (assert_errors == 0 && model_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + MEM_DEPTH + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES)
          * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("Assertion errors: %0d, model errors: %0d", assert_errors, model_errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/mem_pkg.sv
hw/banked_ram.sv
hw/fault_status.sv
hw/cpu_memory_controller.sv
hw/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// ==== Makefile ====
# Verilator simulation of the memory subsystem

TOP = tb_mem_subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
